// File: hw/riscv_mul_pkg.sv
// RISC-V multiply types: operand bus, M-extension opcodes, request and prepared-operand formats
`default_nettype none

package riscv_mul_pkg;

    // Core data path width
    localparam int unsigned XLEN = 64;

    // Operand or result word
    typedef logic [XLEN-1:0] bus64_t;

    // Multiply opcodes, encoded as funct3[1:0] of the OP / OP-32 major opcodes
    typedef enum logic [1:0] {
        MUL_LO  = 2'b00,   // MUL, MULW: low half
        MULH_SS = 2'b01,   // MULH: signed x signed, high half
        MULH_SU = 2'b10,   // MULHSU: signed x unsigned, high half
        MULH_UU = 2'b11    // MULHU: unsigned x unsigned, high half
    } mul_op_e;

    // Request as offered by the issue stage
    typedef struct packed {
        mul_op_e op;
        logic    is_word;   // Word form, only meaningful with MUL_LO
        bus64_t  src1;      // rs1
        bus64_t  src2;      // rs2
    } mul_req_t;

    // Operation after sign handling
    // Both operands are plain magnitudes, the sign of the result rides along in neg
    typedef struct packed {
        mul_op_e op;
        logic    is_word;
        bus64_t  mag1;      // |rs1| or rs1 when unsigned
        bus64_t  mag2;      // |rs2| or rs2 when unsigned
        logic    neg;       // Product must be negated
    } mul_prep_t;

endpackage

`default_nettype wire

// File: hw/mul_cfg_pkg.sv
// Multiply unit microarchitecture constants for request buffering
`default_nettype none

package mul_cfg_pkg;

    // Entries in the prepared-operation FIFO
    localparam int unsigned MUL_FIFO_DEPTH = 4;

    // Read and write pointer width, log2 of the depth
    localparam int unsigned MUL_FIFO_PTR_W = 2;

    // Occupancy counter needs one extra bit to hold a full FIFO
    localparam int unsigned MUL_FIFO_CNT_W = MUL_FIFO_PTR_W + 1;

endpackage

`default_nettype wire

// File: hw/mul_operand_prep.sv
// Multiply operand preparation: registers a request, turns operands into magnitudes plus sign
`timescale 1ns/1ps
`default_nettype none

module mul_operand_prep
    import riscv_mul_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  mul_req_t  req_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  logic      fifo_full_i,
    output mul_prep_t prep_o,
    output logic      prep_valid_o
);

    mul_prep_t prep_d;
    mul_prep_t prep_q;
    logic      valid_q;
    logic      sgn1_en;      // rs1 is treated as signed
    logic      sgn2_en;      // rs2 is treated as signed
    logic      sign1;
    logic      sign2;
    logic      load;         // Register takes new contents this cycle

    // Extend and take the absolute value when the operand counts as signed
    function automatic bus64_t to_mag(input bus64_t src, input logic is_word, input logic neg_src);
        bus64_t ext;
        ext = is_word ? {{32{src[31]}}, src[31:0]} : src;   // Word ops live in the low half
        return neg_src ? (~ext + 64'd1) : ext;
    endfunction

    assign sgn1_en = (req_i.op != MULH_UU);
    assign sgn2_en = (req_i.op == MUL_LO) || (req_i.op == MULH_SS);

    // Sign bit position depends on the word flag
    assign sign1 = sgn1_en & (req_i.is_word ? req_i.src1[31] : req_i.src1[63]);
    assign sign2 = sgn2_en & (req_i.is_word ? req_i.src2[31] : req_i.src2[63]);

    always_comb begin
        prep_d.op      = req_i.op;
        prep_d.is_word = req_i.is_word;
        prep_d.mag1    = to_mag(req_i.src1, req_i.is_word, sign1);
        prep_d.mag2    = to_mag(req_i.src2, req_i.is_word, sign2);
        prep_d.neg     = sign1 ^ sign2;   // Zero for MULHU, rs1 sign for MULHSU
    end

    // Stall only when holding an entry the FIFO cannot take
    assign req_ready_o = ~flush_i & (~valid_q | ~fifo_full_i);
    assign load        = req_ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;            // Drop whatever is waiting
        end else if (load) begin
            valid_q <= req_valid_i;     // Old entry leaves to the FIFO as the new one lands
        end
    end

    always_ff @(posedge clk_i) begin
        if (load && req_valid_i) begin
            prep_q <= prep_d;
        end
    end

    assign prep_o       = prep_q;
    assign prep_valid_o = valid_q;

    // A held entry waits for the FIFO, it is only ever discarded by a flush
    a_hold_when_full : assert property (@(posedge clk_i) disable iff (!rstn_i)
        prep_valid_o && fifo_full_i && !flush_i |=> prep_valid_o && $stable(prep_o))
        else $error("prepared operation dropped while FIFO full");

endmodule

`default_nettype wire

// File: hw/mul_req_fifo.sv
// Multiply request FIFO: queues prepared operations between preparation and the multiply core
`timescale 1ns/1ps
`default_nettype none

module mul_req_fifo
    import riscv_mul_pkg::*;
    import mul_cfg_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  logic      push_i,
    input  mul_prep_t data_i,
    output logic      fifo_full_o,
    output mul_prep_t head_o,
    output logic      head_valid_o,
    input  logic      pop_i
);

    mul_prep_t                 mem_q [MUL_FIFO_DEPTH];
    logic [MUL_FIFO_PTR_W-1:0] wr_ptr_q;
    logic [MUL_FIFO_PTR_W-1:0] rd_ptr_q;
    logic [MUL_FIFO_CNT_W-1:0] count_q;
    logic                      wr_en;
    logic                      rd_en;

    assign fifo_full_o  = (count_q == MUL_FIFO_CNT_W'(MUL_FIFO_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem_q[rd_ptr_q];   // Head shows the oldest entry

    assign wr_en = push_i & ~fifo_full_o;    // Producer keeps offering while full
    assign rd_en = pop_i & head_valid_o;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // None or both, level unchanged
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (wr_en && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Core only pops what it can see
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> head_valid_o)
        else $error("pop from empty FIFO");

    // A push refused for lack of room must be offered again unchanged
    a_no_push_lost : assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i && fifo_full_o && !flush_i |=> push_i && $stable(data_i))
        else $error("push lost while FIFO full");

endmodule

`default_nettype wire

// File: hw/mul_core.sv
// Multiply core: 64x32 partial products, one-cycle word path, two-cycle 64-bit path
`timescale 1ns/1ps
`default_nettype none

module mul_core
    import riscv_mul_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i,
    input  mul_prep_t head_i,
    input  logic      head_valid_i,
    output logic      pop_o,
    output bus64_t    res_o,
    output logic      res_valid_o
);

    typedef enum logic {
        IDLE,
        COMBINE
    } state_e;

    state_e         state_q;
    logic   [95:0]  pp_lo_d;       // mag1 * mag2[31:0]
    logic   [95:0]  pp_hi_d;       // mag1 * mag2[63:32]
    logic   [95:0]  pp_lo_q;
    logic   [95:0]  pp_hi_q;
    mul_op_e        op_q;
    logic           neg_q;
    bus64_t         lo_signed;     // Word path, product low half with sign applied
    bus64_t         res_word;
    logic   [127:0] sum_128;
    logic   [127:0] sum_signed;
    bus64_t         res_wide;
    bus64_t         res_q;
    logic           res_valid_q;
    logic           res_word_q;    // Last result came from the word path

    // Take a new operation whenever idle, the same cycle it shows up
    assign pop_o = (state_q == IDLE) & head_valid_i & ~flush_i;

    assign pp_lo_d = head_i.mag1 * head_i.mag2[31:0];
    assign pp_hi_d = head_i.mag1 * head_i.mag2[63:32];

    // Word ops have 32-bit magnitudes, so the low product alone is enough
    assign lo_signed = head_i.neg ? (~pp_lo_d[63:0] + 64'd1) : pp_lo_d[63:0];
    assign res_word  = {{32{lo_signed[31]}}, lo_signed[31:0]};

    // Recombine with the high partial product shifted by 32
    assign sum_128    = {32'b0, pp_lo_q} + {pp_hi_q, 32'b0};
    assign sum_signed = neg_q ? (~sum_128 + 128'd1) : sum_128;
    assign res_wide   = (op_q == MUL_LO) ? sum_signed[63:0] : sum_signed[127:64];

    // Control, flush returns to idle and kills the pending pulse
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            state_q     <= IDLE;
            res_valid_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    res_valid_q <= pop_o & head_i.is_word;   // Word ops finish here
                    if (pop_o && !head_i.is_word) begin
                        state_q <= COMBINE;
                    end
                end
                COMBINE: begin
                    res_valid_q <= 1'b1;
                    state_q     <= IDLE;   // Free for a new pop during the pulse
                end
                default: begin
                    res_valid_q <= 1'b0;
                    state_q     <= IDLE;
                end
            endcase
        end
    end

    // Data path registers
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            pp_lo_q    <= pp_lo_d;
            pp_hi_q    <= pp_hi_d;
            op_q       <= head_i.op;
            neg_q      <= head_i.neg;
        end
        if (pop_o && head_i.is_word) begin
            res_q      <= res_word;
            res_word_q <= 1'b1;
        end else if (state_q == COMBINE) begin
            res_q      <= res_wide;
            res_word_q <= 1'b0;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

    // A 64-bit result needs a combine cycle, so it never directly follows another pulse
    a_wide_spacing : assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o && !res_word_q |-> !$past(res_valid_o))
        else $error("64-bit result back to back with previous result");

endmodule

`default_nettype wire

// File: hw/mul_top.sv
// Multiply unit top: operand preparation, request FIFO and multiply core in a chain
`timescale 1ns/1ps
`default_nettype none

module mul_top
    import riscv_mul_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     flush_i,
    input  mul_req_t req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    output bus64_t   res_o,
    output logic     res_valid_o
);

    mul_prep_t prep;          // Producer register to FIFO
    logic      prep_valid;
    logic      fifo_full;
    mul_prep_t head;          // FIFO head to core
    logic      head_valid;
    logic      pop;

    // Producer
    mul_operand_prep prep_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .fifo_full_i  (fifo_full),
        .prep_o       (prep),
        .prep_valid_o (prep_valid)
    );

    // Buffer, refuses the push itself when full
    mul_req_fifo fifo_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .push_i       (prep_valid),
        .data_i       (prep),
        .fifo_full_o  (fifo_full),
        .head_o       (head),
        .head_valid_o (head_valid),
        .pop_i        (pop)
    );

    // Consumer
    mul_core core_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o)
    );

endmodule

`default_nettype wire

// File: sim/mul_checker.sv
// Multiply result checker: queues expected results in request order and compares DUT results
`timescale 1ns/1ps
`default_nettype none

module mul_checker
    import riscv_mul_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   flush_i,
    input  logic   accept_i,      // Request handshake completes this edge
    input  bus64_t exp_i,         // Reference value for the request on the bus
    input  logic   res_valid_i,
    input  bus64_t res_i,
    output int     err_cnt_o,
    output int     pending_o,     // Expected results not yet seen
    output int     accepted_o,
    output int     results_o,
    output int     dropped_o      // Discarded by flush
);

    bus64_t exp_q [$];
    bus64_t exp_val;

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exp_q.delete();
            err_cnt_o  = 0;
            pending_o  = 0;
            accepted_o = 0;
            results_o  = 0;
            dropped_o  = 0;
        end else begin
            if (flush_i) begin
                // Anything in flight is killed, a pulse in this cycle belongs to it too
                dropped_o += exp_q.size();
                exp_q.delete();
            end else if (res_valid_i) begin
                results_o++;
                if (exp_q.size() == 0) begin
                    $display("%0t: result %h arrived with no request outstanding", $time, res_i);
                    err_cnt_o++;
                end else begin
                    exp_val = exp_q.pop_front();   // Results leave in request order
                    if (res_i !== exp_val) begin
                        $display("mismatch at %0t: res_o expected %h actual %h",
                                 $time, exp_val, res_i);
                        err_cnt_o++;
                    end
                end
            end
            // Earliest result is several edges away, so push after the compare
            if (accept_i) begin
                exp_q.push_back(exp_i);
                accepted_o++;
            end
            pending_o = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mul_top.sv
// Multiply unit testbench: corner, word, random, back-pressure and flush tests against a model
`timescale 1ns/1ps
`default_nettype none

module tb_mul_top
    import riscv_mul_pkg::*;
();

    localparam int unsigned WAIT_MAX = 200;   // Cycles before any wait gives up

    logic        clk;
    logic        rstn;
    logic        flush;
    mul_req_t    req;
    logic        req_valid;
    logic        req_ready;
    bus64_t      res;
    logic        res_valid;
    bus64_t      exp_val;
    int          seed = 96488;
    int          tb_errors;
    int          chk_errors;
    int          pending;
    int          accepted;
    int          results;
    int          dropped;
    logic        stall_seen;                 // req_ready_o seen low while offering
    bus64_t      corner64 [5];
    logic [31:0] corner32 [5];

    // RISC-V M semantics, 128-bit product of extended operands
    function automatic bus64_t mul_ref(input mul_op_e op, input logic is_word,
                                       input bus64_t a, input bus64_t b);
        logic [127:0] ext_a;
        logic [127:0] ext_b;
        logic [127:0] prod;
        logic [31:0]  prod_w;
        prod_w = a[31:0] * b[31:0];          // MULW keeps only the low word
        ext_a  = (op == MULH_UU) ? {64'b0, a} : {{64{a[63]}}, a};
        ext_b  = (op == MUL_LO || op == MULH_SS) ? {{64{b[63]}}, b} : {64'b0, b};
        prod   = ext_a * ext_b;
        if (is_word) begin
            return {{32{prod_w[31]}}, prod_w};
        end
        return (op == MUL_LO) ? prod[63:0] : prod[127:64];
    endfunction

    function automatic bus64_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    assign exp_val = mul_ref(req.op, req.is_word, req.src1, req.src2);

    always #2 clk = ~clk;                    // 4 ns period

    mul_top dut_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .flush_i     (flush),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .res_o       (res),
        .res_valid_o (res_valid)
    );

    mul_checker chk_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .flush_i     (flush),
        .accept_i    (req_valid & req_ready),
        .exp_i       (exp_val),
        .res_valid_i (res_valid),
        .res_i       (res),
        .err_cnt_o   (chk_errors),
        .pending_o   (pending),
        .accepted_o  (accepted),
        .results_o   (results),
        .dropped_o   (dropped)
    );

    // Offer one request and hold it until taken, returns 1 ns after the accepting edge
    task automatic send(input mul_op_e op, input logic is_word, input bus64_t a, input bus64_t b);
        int   waited;
        logic taken;
        waited      = 0;
        taken       = 1'b0;
        req.op      = op;
        req.is_word = is_word;
        req.src1    = a;
        req.src2    = b;
        req_valid   = 1'b1;
        while (!taken && waited < WAIT_MAX) begin
            @(negedge clk);
            taken = req_ready;               // Mid-cycle, stable until the edge
            if (!taken) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (!taken) begin
            $display("%0t: timeout waiting for req_ready_o", $time);
            tb_errors++;
        end
    endtask

    // Word form only goes with MUL_LO
    task automatic send_random(input logic wide_only);
        mul_op_e op;
        logic    is_word;
        int      r;
        r       = $random(seed);
        op      = mul_op_e'(r[1:0]);
        is_word = !wide_only && (op == MUL_LO) && r[2];
        send(op, is_word, rand64(), rand64());
    endtask

    // Stop offering and wait for every accepted request to come back
    task automatic drain();
        int waited;
        waited    = 0;
        req_valid = 1'b0;
        @(negedge clk);
        while (pending != 0 && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("%0t: timeout waiting for %0d outstanding results", $time, pending);
            tb_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    // One flush cycle, the last request stays on the bus and must not be taken
    task automatic flush_pulse();
        flush = 1'b1;
        @(negedge clk);
        if (req_ready !== 1'b0) begin
            $display("%0t: req_ready_o high during flush", $time);
            tb_errors++;
        end
        @(posedge clk);
        #1;
        flush     = 1'b0;
        req_valid = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        flush       = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        tb_errors   = 0;
        stall_seen  = 1'b0;
        corner64[0] = 64'h0;
        corner64[1] = 64'h1;
        corner64[2] = 64'hffff_ffff_ffff_ffff;
        corner64[3] = 64'h8000_0000_0000_0000;
        corner64[4] = 64'h7fff_ffff_ffff_ffff;
        corner32[0] = 32'h0;
        corner32[1] = 32'h1;
        corner32[2] = 32'hffff_ffff;
        corner32[3] = 32'h8000_0000;
        corner32[4] = 32'h7fff_ffff;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Idle outputs before any request
        @(negedge clk);
        if (req_ready !== 1'b1 || res_valid !== 1'b0) begin
            $display("%0t: wrong req_ready_o or res_valid_o after reset", $time);
            tb_errors++;
        end
        @(posedge clk);
        #1;

        // Every opcode, 64-bit form, on corner pairs
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send(mul_op_e'(op[1:0]), 1'b0, corner64[i], corner64[j]);
                end
            end
        end
        drain();

        // MULW, junk in the upper halves must not leak into the result
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                send(MUL_LO, 1'b1, {$random(seed), corner32[i]}, {$random(seed), corner32[j]});
            end
        end
        repeat (20) send(MUL_LO, 1'b1, rand64(), rand64());
        drain();

        repeat (40) send_random(1'b0);       // Mixed, valid held high
        drain();

        // Wide ops drain at half rate, so the FIFO fills
        stall_seen = 1'b0;
        repeat (24) send_random(1'b1);
        drain();
        if (!stall_seen) begin
            $display("%0t: req_ready_o never dropped during the long burst", $time);
            tb_errors++;
        end

        // Partly accepted burst killed, then fresh traffic
        repeat (6) send_random(1'b0);
        flush_pulse();
        repeat (10) send_random(1'b0);
        drain();

        if (pending != 0 || accepted != results + dropped) begin
            $display("%0t: %0d results plus %0d flushed do not match %0d accepted requests",
                     $time, results, dropped, accepted);
            tb_errors++;
        end
        $display("errors: %0d (checker %0d, testbench %0d)",
                 chk_errors + tb_errors, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/riscv_mul_pkg.sv
hw/mul_cfg_pkg.sv
hw/mul_operand_prep.sv
hw/mul_req_fifo.sv
hw/mul_core.sv
hw/mul_top.sv
sim/mul_checker.sv
sim/tb_mul_top.sv

// File: Bender.yml
package:
  name: riscv_mul

sources:
  - hw/riscv_mul_pkg.sv
  - hw/mul_cfg_pkg.sv
  - hw/mul_operand_prep.sv
  - hw/mul_req_fifo.sv
  - hw/mul_core.sv
  - hw/mul_top.sv
  - target: simulation
    files:
      - sim/mul_checker.sv
      - sim/tb_mul_top.sv
